// ==== logic/rvPkg.sv ====
package rvPkg;

    localparam int xlen       = 32;
    localparam int regAddrW   = 5;
    localparam int nRegs      = 32;
    localparam int shamtW     = 5;   // shift amount taken from low bits of b
    localparam int instrBytes = 4;   // sequential pc step

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opBranch = 7'b1100011
    } opcodeE;

    // decode class for the ALU decoder, same coding as the old ALUOp
    typedef enum logic [1:0] {
        clsMem    = 2'b00,
        clsImm    = 2'b01,
        clsReg    = 2'b10,
        clsBranch = 2'b11
    } aluClassE;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,
        aluShl = 4'd6,
        aluShr = 4'd7,
        aluSge = 4'd8,
        aluEq  = 4'd9,
        aluNe  = 4'd10
    } aluOpE;

    typedef enum logic [1:0] {
        immI = 2'd0,
        immS = 2'd1,
        immB = 2'd2
    } immKindE;

    typedef struct packed {
        logic    regWrite;
        logic    memWrite;
        logic    memToReg;
        logic    aluSrcImm;   // b operand from immediate
        logic    branch;
        immKindE immKind;
        aluOpE   aluOp;
    } ctrlS;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            write;
    } dmemReqS;

endpackage

// ==== logic/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder (
    input  rvPkg::aluClassE aluClass,
    input  logic [2:0]      funct3,
    input  logic            funct7b5,
    output rvPkg::aluOpE    aluOp
);
    import rvPkg::*;

    always_comb begin
        aluOp = aluAdd;   // loads, stores and anything unlisted
        case (aluClass)
            clsMem: begin
                aluOp = aluAdd;   // address = rs1 + imm
            end
            clsImm: begin
                case (funct3)
                    3'b000:  aluOp = aluAdd;
                    3'b001:  aluOp = aluShl;
                    3'b010:  aluOp = aluSlt;
                    3'b011:  aluOp = aluSlt;   // sltiu treated as signed
                    3'b100:  aluOp = aluXor;
                    3'b101:  aluOp = aluShr;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    default: aluOp = aluAdd;
                endcase
            end
            clsReg: begin
                case (funct3)
                    3'b000:  aluOp = funct7b5 ? aluSub : aluAdd;
                    3'b001:  aluOp = aluShl;
                    3'b010:  aluOp = aluSlt;
                    3'b100:  aluOp = aluXor;
                    3'b101:  aluOp = aluShr;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    default: aluOp = aluAdd;   // sltu not supported
                endcase
            end
            clsBranch: begin
                case (funct3)
                    3'b000:  aluOp = aluEq;    // beq
                    3'b001:  aluOp = aluNe;    // bne
                    3'b100:  aluOp = aluSlt;   // blt
                    3'b101:  aluOp = aluSge;   // bge
                    default: aluOp = aluAdd;   // unsigned branches never taken
                endcase
            end
            default: aluOp = aluAdd;
        endcase
    end

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  logic [rvPkg::xlen-1:0] instr,
    input  logic                   rstN,
    output rvPkg::ctrlS            ctrl
);
    import rvPkg::*;

    opcodeE   opcode;
    aluClassE aluClass;
    aluOpE    decOp;
    logic     known;   // opcode is in the supported set

    assign opcode = opcodeE'(instr[6:0]);

    aluDecoder aluDec (
        .aluClass (aluClass),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .aluOp    (decOp)
    );

    always_comb begin
        ctrl     = '0;
        aluClass = clsMem;
        known    = 1'b1;
        ctrl.immKind = immI;
        case (opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                aluClass      = clsReg;
            end
            opImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                aluClass       = clsImm;
            end
            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                aluClass       = clsMem;
            end
            opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immKind   = immS;
                aluClass       = clsMem;
            end
            opBranch: begin
                ctrl.branch  = 1'b1;   // compare rs1 with rs2
                ctrl.immKind = immB;
                aluClass     = clsBranch;
            end
            default: begin
                known = 1'b0;
            end
        endcase
        ctrl.aluOp = decOp;

        // no side effects while in reset or on an unknown opcode
        if (!rstN || !known) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch   = 1'b0;
        end
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    input  rvPkg::aluOpE           op,
    output logic [rvPkg::xlen-1:0] result,
    output logic                   cond
);
    import rvPkg::*;

    logic [shamtW-1:0] shamt;
    logic              lessThan;

    assign shamt    = b[shamtW-1:0];
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        result = '0;
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluXor: result = a ^ b;
            aluShl: result = a << shamt;
            aluShr: result = a >> shamt;   // logical only
            aluSlt: result = {{(xlen-1){1'b0}}, lessThan};
            aluSge: result = {{(xlen-1){1'b0}}, ~lessThan};
            aluEq:  result = {{(xlen-1){1'b0}}, a == b};
            aluNe:  result = {{(xlen-1){1'b0}}, a != b};
            default: result = a + b;
        endcase
    end

    // branch condition, only meaningful for compares
    always_comb begin
        case (op)
            aluSlt, aluSge, aluEq, aluNe: cond = result[0];
            default:                      cond = 1'b0;
        endcase
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                       clk,
    input  logic [rvPkg::regAddrW-1:0] rs1,
    input  logic [rvPkg::regAddrW-1:0] rs2,
    input  logic [rvPkg::regAddrW-1:0] rd,
    input  logic [rvPkg::xlen-1:0]     wdata,
    input  logic                       wen,
    output logic [rvPkg::xlen-1:0]     rs1Data,
    output logic [rvPkg::xlen-1:0]     rs2Data
);
    import rvPkg::*;

    logic [xlen-1:0] regs [nRegs];

    always_ff @(posedge clk) begin
        if (wen && rd != '0) begin   // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    // asynchronous reads
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  logic [rvPkg::xlen-1:0] instr,
    input  rvPkg::immKindE         kind,
    output logic [rvPkg::xlen-1:0] imm
);
    import rvPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (kind)
            immS: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                // offset in halfwords, bit 0 always zero
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, instr[31:20]};   // immI
            end
        endcase
    end

endmodule

// ==== logic/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   branch,
    input  logic                   cond,
    input  logic [rvPkg::xlen-1:0] imm,
    output logic [rvPkg::xlen-1:0] pc
);
    import rvPkg::*;

    logic [xlen-1:0] nextPc;

    assign nextPc = (branch && cond) ? pc + imm : pc + xlen'(instrBytes);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;   // first fetch from address 0
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== logic/rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
    input  logic                   clk,
    input  logic                   rstN,
    output logic [rvPkg::xlen-1:0] imemAddr,
    input  logic [rvPkg::xlen-1:0] imemData,
    output rvPkg::dmemReqS         dmemReq,
    input  logic [rvPkg::xlen-1:0] dmemRdata
);
    import rvPkg::*;

    ctrlS            ctrl;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] result;
    logic [xlen-1:0] wbData;
    logic            cond;

    controlUnit ctrlUnit (
        .instr (imemData),
        .rstN  (rstN),
        .ctrl  (ctrl)
    );

    regFile regs (
        .clk     (clk),
        .rs1     (imemData[19:15]),
        .rs2     (imemData[24:20]),
        .rd      (imemData[11:7]),
        .wdata   (wbData),
        .wen     (ctrl.regWrite),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    immGen immUnit (
        .instr (imemData),
        .kind  (ctrl.immKind),
        .imm   (imm)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    alu aluUnit (
        .a      (rs1Data),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (result),
        .cond   (cond)
    );

    pcUnit pcReg (
        .clk    (clk),
        .rstN   (rstN),
        .branch (ctrl.branch),
        .cond   (cond),
        .imm    (imm),
        .pc     (pc)
    );

    assign wbData   = ctrl.memToReg ? dmemRdata : result;
    assign imemAddr = pc;

    // store data always comes from rs2, address from the ALU
    assign dmemReq.addr  = result;
    assign dmemReq.wdata = rs2Data;
    assign dmemReq.write = ctrl.memWrite;

endmodule

// ==== bench/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb;
    import rvPkg::*;

    localparam logic [31:0] doneAddr = 32'h7FC;   // last store of the program
    localparam int maxCycles = 400;

    logic        clk = 1'b0;
    logic        rstN;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    dmemReqS     dmemReq;
    logic [31:0] dmemRdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [512];
    logic [31:0] mRegs [32];   // reference register file
    logic [31:0] mPc;
    logic [31:0] seed = 32'he40e;
    logic [11:0] slot = 12'h100;   // next free result word
    int          wp = 0;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic        doneSeen = 1'b0;

    rvCore UUT (
        .clk       (clk),
        .rstN      (rstN),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemReq   (dmemReq),
        .dmemRdata (dmemRdata)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // memories answer within the cycle
    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRdata = dmem[dmemReq.addr[10:2]];

    always @(posedge clk) begin
        if (dmemReq.write) dmem[dmemReq.addr[10:2]] <= dmemReq.wdata;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] encR(input logic [2:0] f3, input logic sub,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};   // base is x0
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // expected result from funct3, shift amounts limited to 5 bits
    function automatic logic [31:0] expectAlu(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:       return sub ? a - b : a + b;
            3'd1:       return a << b[4:0];
            3'd2, 3'd3: return {31'd0, $signed(a) < $signed(b)};   // sltiu is signed here
            3'd4:       return a ^ b;
            3'd5:       return a >> b[4:0];
            3'd6:       return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[wp] = word;
        wp++;
    endtask

    task automatic emitStore(input logic [4:0] rs2);
        emit(encS(rs2, slot));
        slot = slot + 12'd4;
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        logic [11:0] imm;
        logic [2:0]  f3;
        emitStore(5'd0);   // first word is a store, held off during reset
        emit(encI(7'b0000011, 3'b010, 5'd1, 5'd0, 12'd0));   // lw x1, 0(x0)
        emit(encI(7'b0000011, 3'b010, 5'd2, 5'd0, 12'd4));   // lw x2, 4(x0)
        for (int f = 0; f < 8; f++) begin
            if (f != 3) begin
                emit(encR(3'(f), 1'b0, 5'd3, 5'd1, 5'd2));
                emitStore(5'd3);
            end
        end
        emit(encR(3'd0, 1'b1, 5'd3, 5'd1, 5'd2));   // sub
        emitStore(5'd3);
        for (int n = 0; n < 16; n++) begin
            r   = nextRand();
            f3  = 3'(n % 8);
            imm = (f3 == 3'd1 || f3 == 3'd5) ? {7'd0, r[4:0]} : r[11:0];
            emit(encI(7'b0010011, f3, 5'd4, 5'd1, imm));
            emitStore(5'd4);
        end
        emit(encI(7'b0010011, 3'd0, 5'd0, 5'd1, 12'h123));   // addi x0 has no effect
        emitStore(5'd0);
        emit(32'h0020_818B);   // custom-0 opcode, rd = x3
        emitStore(5'd3);
        emit(encI(7'b0010011, 3'd0, 5'd5, 5'd1, 12'd0));     // x5 equal to x1
        emit(encI(7'b0010011, 3'd0, 5'd6, 5'd1, 12'hFFF));   // x6 below x1
        emit(encI(7'b0010011, 3'd0, 5'd7, 5'd1, 12'd1));     // x7 above x1
        emit(encI(7'b0010011, 3'd0, 5'd9, 5'd0, 12'd0));
        for (int k = 0; k < 4; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int s = 5; s <= 7; s++) begin
                emit(encB(f3, 5'd1, 5'(s), 13'd8));   // taken skips the increment
                emit(encI(7'b0010011, 3'd0, 5'd9, 5'd9, 12'd1));
            end
        end
        emitStore(5'd9);
        emit(encS(5'd1, doneAddr[11:0]));
    endtask

    task automatic flagMismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    // reference model, checked and advanced once per cycle while outputs are stable
    always @(negedge clk) begin : refModel
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] nextPc;
        logic [31:0] wval;
        logic        wr;
        logic        expWrite;
        checks++;
        if (!rstN) begin
            assert (imemAddr == 32'd0 && !dmemReq.write)
                else flagMismatch($sformatf("in reset pc %h write %b", imemAddr, dmemReq.write));
            mPc = 32'd0;
        end else begin
            ins      = imem[mPc[9:2]];
            a        = mRegs[ins[19:15]];
            b        = mRegs[ins[24:20]];
            immI     = {{20{ins[31]}}, ins[31:20]};
            immS     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB     = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            nextPc   = mPc + 32'd4;
            wval     = 32'd0;
            wr       = 1'b0;
            expWrite = 1'b0;
            case (ins[6:0])
                7'b0110011: begin
                    wr   = 1'b1;
                    wval = expectAlu(ins[14:12], ins[30], a, b);
                end
                7'b0010011: begin
                    wr   = 1'b1;
                    wval = expectAlu(ins[14:12], 1'b0, a, immI);
                end
                7'b0000011: begin
                    wr   = 1'b1;
                    wval = dmem[9'((a + immI) >> 2)];   // operand words are never stored to
                end
                7'b0100011: expWrite = 1'b1;
                7'b1100011: if (branchTaken(ins[14:12], a, b)) nextPc = mPc + immB;
                default: ;   // unknown opcode
            endcase
            assert (imemAddr == mPc)
                else flagMismatch($sformatf("pc %h, expected %h", imemAddr, mPc));
            assert (dmemReq.write == expWrite)
                else flagMismatch($sformatf("store strobe %b at pc %h", dmemReq.write, mPc));
            if (expWrite) begin
                checks++;
                assert (dmemReq.addr == a + immS && dmemReq.wdata == b)
                    else flagMismatch($sformatf("store %h to %h, expected %h to %h",
                                                dmemReq.wdata, dmemReq.addr, b, a + immS));
                if (a + immS == doneAddr) doneSeen = 1'b1;
            end
            if (wr && ins[11:7] != 5'd0) mRegs[ins[11:7]] = wval;
            mPc = nextPc;
        end
    end

    initial begin : stimulus
        int cyc;
        rstN = 1'b0;
        for (int i = 0; i < 256; i++) imem[i] = 32'd0;   // zero words decode as unknown
        for (int i = 0; i < 512; i++) dmem[i] = nextRand();
        for (int i = 0; i < 32; i++) mRegs[i] = 32'd0;
        mPc = 32'd0;
        buildProgram();
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;
        for (cyc = 0; cyc < maxCycles && !doneSeen; cyc++) @(posedge clk);
        if (!doneSeen) begin
            timeouts++;
            $display("timeout: program did not reach its final store in %0d cycles", maxCycles);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/rvPkg.sv
logic/aluDecoder.sv
logic/controlUnit.sv
logic/alu.sv
logic/regFile.sv
logic/immGen.sv
logic/pcUnit.sv
logic/rvCore.sv
bench/rvCoreTb.sv

// ==== Makefile ====
SRCS := $(wildcard logic/*.sv bench/*.sv)

.PHONY: run clean

run: obj_dir/VrvCoreTb
	@out="$$(./obj_dir/VrvCoreTb)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

obj_dir/VrvCoreTb: sim.f $(SRCS)
	verilator --binary --assert --top-module rvCoreTb -f sim.f --Mdir obj_dir

clean:
	rm -rf obj_dir
